//--- src/cnn_cmd_pkg.sv
`default_nettype none

package cnn_cmd_pkg;

    // Layer operation codes, 6 and 7 have no meaning
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        CONV1X1     = 3'd1,  // Conv 1x1 + ReLU
        CONV3X3     = 3'd2,  // Conv 3x3 + ReLU
        CONV3X3_PAD = 3'd3,  // Conv 3x3 padded
        MAXPOOL     = 3'd4,  // 3x3 max
        AVEPOOL     = 3'd5   // 13x13 average
    } op_type_e;

    localparam int CMD_WORDS = 6;   // 192-bit compressed command
    localparam int CMD_IW    = 3;   // Word index width
    localparam int GROUP_CH  = 16;  // Output channels per engine pulse

    localparam int CH_W   = 16;
    localparam int ADDR_W = 32;
    localparam int OP_W   = 3;

    // Word order within a command
    // Stride, padding and kernel bits ride along and stay unused
    localparam logic [CMD_IW-1:0] W_OP     = 3'd0;  // op_type, padding, strides
    localparam logic [CMD_IW-1:0] W_OCH    = 3'd1;  // In/out channel sizes
    localparam logic [CMD_IW-1:0] W_OPS    = 3'd2;  // Kernel sizes, op count
    localparam logic [CMD_IW-1:0] W_WADDR  = 3'd3;
    localparam logic [CMD_IW-1:0] W_DADDR  = 3'd4;
    localparam logic [CMD_IW-1:0] W_WBADDR = 3'd5;

    localparam int OP_LSB  = 0;
    localparam int CNT_LSB = 16;  // Out channels in word 1, op count in word 2

endpackage

`default_nettype wire

//--- src/cnn_bus_pkg.sv
`default_nettype none

package cnn_bus_pkg;

    localparam int APB_AW     = 8;
    localparam int APB_DW     = 32;
    localparam int NUM_PORTS  = 4;
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;
    localparam int FIFO_CW    = 7;  // Counts 0..64

    // Register map
    localparam logic [APB_AW-1:0] REG_CTRL    = 8'h00;  // bit 0 start
    localparam logic [APB_AW-1:0] REG_CMD     = 8'h04;  // Write pushes a word
    localparam logic [APB_AW-1:0] REG_STATUS  = 8'h08;
    localparam logic [APB_AW-1:0] REG_IRQ_CLR = 8'h0C;
    localparam logic [APB_AW-1:0] REG_OPS     = 8'h10;  // Completed commands

    // STATUS fields
    localparam int ST_IRQ     = 0;
    localparam int ST_RUN     = 1;
    localparam int ST_BAD     = 2;
    localparam int ST_CNT_LSB = 8;

    // DMA read-port sets
    localparam logic [NUM_PORTS-1:0] PORTS_01  = 4'b0011;
    localparam logic [NUM_PORTS-1:0] PORTS_23  = 4'b1100;
    localparam logic [NUM_PORTS-1:0] PORTS_ALL = 4'b1111;

endpackage

`default_nettype wire

//--- src/cmd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_fifo (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              i_push,
    input  wire  [31:0]                      i_wdata,
    input  wire                              i_pop,
    output logic [31:0]                      o_rdata,
    output logic [cnn_bus_pkg::FIFO_CW-1:0]  o_count,
    output logic                             o_empty,
    output logic                             o_full
);
    import cnn_bus_pkg::*;

    logic [31:0]        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == FIFO_CW'(FIFO_DEPTH));
    assign do_push = i_push && !o_full;   // Drop when full
    assign do_pop  = i_pop && !o_empty;
    assign o_rdata = mem[rd_ptr];         // Head always visible

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= i_wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: ;                // Both or neither
            endcase
        end
    end

    // Sequencer only pops a full command it has seen counted
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_pop && o_empty));

endmodule

`default_nettype wire

//--- src/csb_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module csb_apb_regs (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              i_psel,
    input  wire                              i_penable,
    input  wire                              i_pwrite,
    input  wire  [cnn_bus_pkg::APB_AW-1:0]   i_paddr,
    input  wire  [cnn_bus_pkg::APB_DW-1:0]   i_pwdata,
    output logic [cnn_bus_pkg::APB_DW-1:0]   o_prdata,
    output logic                             o_pready,
    output logic                             o_pslverr,
    output logic                             o_start,
    output logic                             o_push,
    output logic [31:0]                      o_wdata,
    input  wire  [cnn_bus_pkg::FIFO_CW-1:0]  i_fifo_count,
    input  wire                              i_fifo_full,
    input  wire                              i_op_run,
    input  wire                              i_finish,
    input  wire                              i_bad_cmd,
    input  wire                              i_op_done,
    output logic                             o_irq
);
    import cnn_bus_pkg::*;

    logic              access;
    logic              mapped;
    logic              wr_deny;
    logic              wr_ok;
    logic              irq_clr;
    logic              bad_cmd;
    logic [APB_DW-1:0] ops_cnt;

    assign access   = i_psel && i_penable;
    assign o_pready = access;  // No wait states

    // Address decode
    always_comb begin
        mapped  = 1'b1;
        wr_deny = 1'b0;
        case (i_paddr)
            REG_CTRL, REG_IRQ_CLR: ;
            REG_CMD:               wr_deny = i_fifo_full;
            REG_STATUS, REG_OPS:   wr_deny = 1'b1;  // Read-only
            default:               mapped  = 1'b0;
        endcase
    end

    assign o_pslverr = access && (!mapped || (i_pwrite && wr_deny));
    assign wr_ok     = access && i_pwrite && mapped && !wr_deny;
    assign o_push    = wr_ok && (i_paddr == REG_CMD);
    assign o_wdata   = i_pwdata;
    assign o_start   = wr_ok && (i_paddr == REG_CTRL) && i_pwdata[0];  // Pulse, self-clears
    assign irq_clr   = wr_ok && (i_paddr == REG_IRQ_CLR) && i_pwdata[0];

    // Sticky flags, set wins over clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_irq   <= 1'b0;
            bad_cmd <= 1'b0;
            ops_cnt <= '0;
        end else begin
            if (i_finish)
                o_irq <= 1'b1;
            else if (irq_clr)
                o_irq <= 1'b0;
            if (i_bad_cmd)
                bad_cmd <= 1'b1;
            else if (irq_clr)
                bad_cmd <= 1'b0;
            if (i_op_done)
                ops_cnt <= ops_cnt + 1'b1;
        end
    end

    // Read mux
    always_comb begin
        o_prdata = '0;
        if (access && !i_pwrite) begin
            case (i_paddr)
                REG_STATUS: begin
                    o_prdata[ST_IRQ]                  = o_irq;
                    o_prdata[ST_RUN]                  = i_op_run;
                    o_prdata[ST_BAD]                  = bad_cmd;
                    o_prdata[ST_CNT_LSB +: FIFO_CW]   = i_fifo_count;
                end
                REG_OPS: o_prdata = ops_cnt;
                default: ;  // CTRL and CMD read as zero
            endcase
        end
    end

    // Host must hold psel through the access phase
    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        i_penable |-> i_psel);

endmodule

`default_nettype wire

//--- src/csb_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module csb_sequencer (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                i_start,
    input  wire  [31:0]                        i_cmd,         // FIFO head
    input  wire  [cnn_bus_pkg::FIFO_CW-1:0]    i_fifo_count,
    output logic                               o_pop,
    output cnn_cmd_pkg::op_type_e              o_op_type,
    output logic [cnn_cmd_pkg::CH_W-1:0]       o_op_num,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]     o_weight_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]     o_data_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]     o_wb_addr,
    output logic                               o_op_run,
    output logic                               o_issue,
    output logic                               o_op_done,
    output logic                               o_finish,
    output logic                               o_bad_cmd,
    output logic                               o_conv_run,
    output logic                               o_maxpool_run,
    output logic                               o_avepool_run,
    input  wire                                i_conv_grp,
    input  wire                                i_maxpool_grp,
    input  wire                                i_avepool_grp
);
    import cnn_cmd_pkg::*;
    import cnn_bus_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_COLLECT, S_ISSUE, S_WAIT, S_FINISH} state_e;

    state_e            state;
    state_e            next_state;
    logic [CMD_IW-1:0] word_idx;
    logic [CH_W-1:0]   out_ch;
    logic [CH_W:0]     ch_acc;    // Extra bit so 65535 is reachable
    logic [CH_W:0]     ch_next;
    logic              legal;
    logic              grp;
    logic              last_grp;
    logic              last_word;
    logic              fifo_has_cmd;
    logic              more_cmds;

    // Collect starts only once a whole command sits in the FIFO
    assign fifo_has_cmd = (i_fifo_count >= FIFO_CW'(CMD_WORDS));
    assign more_cmds    = (i_fifo_count != '0);
    assign o_pop        = (state == S_COLLECT) && (word_idx != '0 || fifo_has_cmd);
    assign last_word    = o_pop && (word_idx == CMD_IW'(CMD_WORDS - 1));

    always_comb begin
        case (o_op_type)
            CONV1X1, CONV3X3, CONV3X3_PAD, MAXPOOL, AVEPOOL: legal = 1'b1;
            default: legal = 1'b0;  // IDLE has no engine
        endcase
    end

    // Only the running engine's pulse counts
    assign grp      = (o_conv_run & i_conv_grp) | (o_maxpool_run & i_maxpool_grp)
                    | (o_avepool_run & i_avepool_grp);
    assign ch_next  = ch_acc + (CH_W + 1)'(GROUP_CH);
    assign last_grp = grp && (ch_next >= {1'b0, out_ch});  // Zero channels ends on first group

    assign o_issue   = (state == S_ISSUE) && legal;
    assign o_bad_cmd = (state == S_ISSUE) && !legal;
    assign o_op_done = (state == S_WAIT) && last_grp;
    assign o_finish  = (state == S_FINISH);

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:    if (i_start) next_state = S_COLLECT;  // Start ignored elsewhere
            S_COLLECT: if (last_word) next_state = S_ISSUE;
            S_ISSUE: begin
                if (legal)
                    next_state = S_WAIT;
                else
                    next_state = more_cmds ? S_COLLECT : S_FINISH;
            end
            S_WAIT:    if (last_grp) next_state = more_cmds ? S_COLLECT : S_FINISH;
            S_FINISH:  next_state = S_IDLE;
            default:   next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            word_idx      <= '0;
            ch_acc        <= '0;
            o_op_type     <= IDLE;
            o_op_run      <= 1'b0;
            o_conv_run    <= 1'b0;
            o_maxpool_run <= 1'b0;
            o_avepool_run <= 1'b0;
        end else begin
            state <= next_state;
            if (o_pop)
                word_idx <= last_word ? '0 : word_idx + 1'b1;
            if (o_pop && word_idx == W_OP)
                o_op_type <= op_type_e'(i_cmd[OP_LSB +: OP_W]);
            if (last_word)
                o_op_run <= 1'b1;
            else if (state == S_FINISH)
                o_op_run <= 1'b0;
            // Run lines span the whole wait
            if (o_issue) begin
                ch_acc        <= '0;
                o_conv_run    <= (o_op_type inside {CONV1X1, CONV3X3, CONV3X3_PAD});
                o_maxpool_run <= (o_op_type == MAXPOOL);
                o_avepool_run <= (o_op_type == AVEPOOL);
            end else if (o_op_done) begin
                o_conv_run    <= 1'b0;
                o_maxpool_run <= 1'b0;
                o_avepool_run <= 1'b0;
            end else if (grp) begin
                ch_acc <= ch_next;
            end
        end
    end

    // Field unpack, one word per pop
    always_ff @(posedge clk) begin
        if (o_pop) begin
            case (word_idx)
                W_OCH:    out_ch        <= i_cmd[CNT_LSB +: CH_W];
                W_OPS:    o_op_num      <= i_cmd[CNT_LSB +: CH_W];
                W_WADDR:  o_weight_addr <= i_cmd;
                W_DADDR:  o_data_addr   <= i_cmd;
                W_WBADDR: o_wb_addr     <= i_cmd;
                default:  ;
            endcase
        end
    end

    a_one_engine: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({o_conv_run, o_maxpool_run, o_avepool_run}));

endmodule

`default_nettype wire

//--- src/dma_port_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dma_port_ctrl (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                i_issue,
    input  wire                                i_done,
    input  wire cnn_cmd_pkg::op_type_e         i_op_type,
    output logic [cnn_bus_pkg::NUM_PORTS-1:0]  o_rd_en
);
    import cnn_cmd_pkg::*;
    import cnn_bus_pkg::*;

    op_type_e lat_type;  // Type of the running op

    function automatic logic [NUM_PORTS-1:0] port_mask(input op_type_e op);
        case (op)
            CONV1X1:                   port_mask = PORTS_23;
            CONV3X3, MAXPOOL, AVEPOOL: port_mask = PORTS_01;
            CONV3X3_PAD:               port_mask = PORTS_ALL;
            default:                   port_mask = '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_type <= IDLE;
            o_rd_en  <= '0;
        end else if (i_issue) begin
            lat_type <= i_op_type;
            o_rd_en  <= o_rd_en | port_mask(i_op_type);
        end else if (i_done) begin
            o_rd_en  <= o_rd_en & ~port_mask(lat_type);  // Clear only this op's ports
        end
    end

endmodule

`default_nettype wire

//--- src/group_engine.sv
`timescale 1ns/1ns
`default_nettype none

module group_engine #(
    parameter int GROUP_LAT = 3  // Cycles per 16-channel group
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_run,
    output logic o_grp_done
);
    localparam int CW = $clog2(GROUP_LAT + 1);

    logic [CW-1:0] cyc;

    assign o_grp_done = i_run && (cyc == CW'(GROUP_LAT - 1));

    // Held at zero while idle, so each run starts a fresh group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cyc <= '0;
        else if (!i_run || o_grp_done)
            cyc <= '0;
        else
            cyc <= cyc + 1'b1;
    end

endmodule

`default_nettype wire

//--- src/cnn_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module cnn_ctrl_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                i_psel,
    input  wire                                i_penable,
    input  wire                                i_pwrite,
    input  wire  [cnn_bus_pkg::APB_AW-1:0]     i_paddr,
    input  wire  [cnn_bus_pkg::APB_DW-1:0]     i_pwdata,
    output logic [cnn_bus_pkg::APB_DW-1:0]     o_prdata,
    output logic                               o_pready,
    output logic                               o_pslverr,
    output logic                               o_irq,
    output logic                               o_op_run,
    output cnn_cmd_pkg::op_type_e              o_op_type,
    output logic [cnn_cmd_pkg::CH_W-1:0]       o_op_num,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]     o_weight_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]     o_data_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]     o_wb_addr,
    output logic [cnn_bus_pkg::NUM_PORTS-1:0]  o_rd_en
);
    import cnn_bus_pkg::*;

    logic               start;
    logic               push;
    logic               pop;
    logic [31:0]        wdata;
    logic [31:0]        cmd;       // FIFO head
    logic [FIFO_CW-1:0] fifo_count;
    logic               fifo_full;
    logic               issue;
    logic               op_done;
    logic               finish;
    logic               bad_cmd;
    logic               conv_run;
    logic               maxpool_run;
    logic               avepool_run;
    logic               conv_grp;
    logic               maxpool_grp;
    logic               avepool_grp;

    csb_apb_regs u_regs (
        .clk, .rst_n, .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .o_prdata, .o_pready, .o_pslverr,
        .o_start(start), .o_push(push), .o_wdata(wdata),
        .i_fifo_count(fifo_count), .i_fifo_full(fifo_full),
        .i_op_run(o_op_run), .i_finish(finish), .i_bad_cmd(bad_cmd), .i_op_done(op_done),
        .o_irq
    );

    cmd_fifo u_fifo (
        .clk, .rst_n, .i_push(push), .i_wdata(wdata), .i_pop(pop), .o_rdata(cmd),
        .o_count(fifo_count), .o_empty(), .o_full(fifo_full)
    );

    csb_sequencer u_seq (
        .clk, .rst_n, .i_start(start), .i_cmd(cmd), .i_fifo_count(fifo_count), .o_pop(pop),
        .o_op_type, .o_op_num, .o_weight_addr, .o_data_addr, .o_wb_addr, .o_op_run,
        .o_issue(issue), .o_op_done(op_done), .o_finish(finish), .o_bad_cmd(bad_cmd),
        .o_conv_run(conv_run), .o_maxpool_run(maxpool_run), .o_avepool_run(avepool_run),
        .i_conv_grp(conv_grp), .i_maxpool_grp(maxpool_grp), .i_avepool_grp(avepool_grp)
    );

    dma_port_ctrl u_ports (
        .clk, .rst_n, .i_issue(issue), .i_done(op_done), .i_op_type(o_op_type), .o_rd_en
    );

    // Engine latencies differ per kind
    group_engine #(.GROUP_LAT(3)) u_conv    (.clk, .rst_n, .i_run(conv_run),    .o_grp_done(conv_grp));
    group_engine #(.GROUP_LAT(5)) u_maxpool (.clk, .rst_n, .i_run(maxpool_run), .o_grp_done(maxpool_grp));
    group_engine #(.GROUP_LAT(7)) u_avepool (.clk, .rst_n, .i_run(avepool_run), .o_grp_done(avepool_grp));

endmodule

`default_nettype wire

//--- verif/tb_cnn_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cnn_ctrl;
    import cnn_cmd_pkg::*;
    import cnn_bus_pkg::*;

    localparam int N_ROWS    = 9;     // 6 fixed rows, then 3 from the LFSR
    localparam int N_FIXED   = 6;
    localparam int WD_MARGIN = 1000;  // APB traffic and the overflow test

    logic                 clk;
    logic                 rst_n;
    logic                 i_psel;
    logic                 i_penable;
    logic                 i_pwrite;
    logic [APB_AW-1:0]    i_paddr;
    logic [APB_DW-1:0]    i_pwdata;
    logic [APB_DW-1:0]    o_prdata;
    logic                 o_pready;
    logic                 o_pslverr;
    logic                 o_irq;
    logic                 o_op_run;
    op_type_e             o_op_type;
    logic [CH_W-1:0]      o_op_num;
    logic [ADDR_W-1:0]    o_weight_addr;
    logic [ADDR_W-1:0]    o_data_addr;
    logic [ADDR_W-1:0]    o_wb_addr;
    logic [NUM_PORTS-1:0] o_rd_en;

    // Command table, one row per command
    logic [OP_W-1:0]   t_op  [N_ROWS];
    logic [CH_W-1:0]   t_och [N_ROWS];
    logic [CH_W-1:0]   t_num [N_ROWS];
    logic [ADDR_W-1:0] t_wa  [N_ROWS];
    logic [ADDR_W-1:0] t_da  [N_ROWS];
    logic [ADDR_W-1:0] t_wb  [N_ROWS];

    int                   exp_q[$];  // Legal rows not yet issued
    logic [31:0]          lfsr = 32'he24f;
    logic [NUM_PORTS-1:0] prev_rd_en = '0;
    int                   wd_cycles = 0;
    int                   err_cnt = 0;
    int                   n_checks = 0;
    int                   n_tests = 0;
    int                   n_failed = 0;
    int                   n_issues = 0;
    int                   n_legal = 0;
    int                   start_errs = 0;
    string                cur_test;

    cnn_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic is_legal(input logic [OP_W-1:0] op);
        return op inside {CONV1X1, CONV3X3, CONV3X3_PAD, MAXPOOL, AVEPOOL};
    endfunction

    // Read ports each op type needs
    function automatic logic [NUM_PORTS-1:0] ports_for(input logic [OP_W-1:0] op);
        case (op)
            CONV1X1:                   return 4'b1100;
            CONV3X3, MAXPOOL, AVEPOOL: return 4'b0011;
            CONV3X3_PAD:               return 4'b1111;
            default:                   return 4'b0000;  // Illegal, no ports
        endcase
    endfunction

    function automatic int groups_of(input logic [CH_W-1:0] och);
        if (och == '0)
            return 1;  // Zero still runs one group
        return (int'(och) + GROUP_CH - 1) / GROUP_CH;
    endfunction

    function automatic logic [31:0] cmd_word(input int r, input int w);
        case (w)
            0:       return {16'h0101, 13'h0, t_op[r]};  // Stride, pad bits unused
            1:       return {t_och[r], 16'h0040};        // Input channels unused
            2:       return {t_num[r], 16'h0303};        // Kernel sizes unused
            3:       return t_wa[r];
            4:       return t_da[r];
            default: return t_wb[r];
        endcase
    endfunction

    task automatic set_row(input int r, input logic [OP_W-1:0] op, input logic [CH_W-1:0] och,
                           input logic [CH_W-1:0] num, input logic [ADDR_W-1:0] wa,
                           input logic [ADDR_W-1:0] da, input logic [ADDR_W-1:0] wb);
        t_op[r]  = op;
        t_och[r] = och;
        t_num[r] = num;
        t_wa[r]  = wa;
        t_da[r]  = da;
        t_wb[r]  = wb;
    endtask

    task automatic report(input logic ok, input string sig, input string got, input string exp);
        n_checks++;
        if (!ok) begin
            err_cnt++;
            $display("ERROR t=%0t %s got=%s exp=%s", $time, sig, got, exp);
        end
    endtask

    task automatic check_op(input string sig, input op_type_e got, input op_type_e exp);
        report(got === exp, sig, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_addr(input string sig, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        report(got === exp, sig, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_ports(input string sig, input logic [NUM_PORTS-1:0] got,
                               input logic [NUM_PORTS-1:0] exp);
        report(got === exp, sig, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_reg(input string sig, input logic [APB_DW-1:0] got,
                             input logic [APB_DW-1:0] exp);
        report(got === exp, sig, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_num(input string sig, input logic [CH_W-1:0] got,
                             input logic [CH_W-1:0] exp);
        report(got === exp, sig, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        report(got === exp, sig, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    // Setup then access phase, response sampled mid access
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err);
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b1;
        i_paddr   <= addr;
        i_pwdata  <= data;
        @(posedge clk);
        i_penable <= 1'b1;
        @(negedge clk);
        err = o_pslverr;
        check_bit("o_pready", o_pready, 1'b1);  // Zero wait states
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= addr;
        @(posedge clk);
        i_penable <= 1'b1;
        @(negedge clk);
        data = o_prdata;
        err  = o_pslverr;
        check_bit("o_pready", o_pready, 1'b1);
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic read_check(input logic [APB_AW-1:0] addr, input string sig,
                              input logic [APB_DW-1:0] exp);
        logic [APB_DW-1:0] rd;
        logic              err;
        apb_read(addr, rd, err);
        check_reg(sig, rd, exp);
        check_bit({sig, " pslverr"}, err, 1'b0);
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        start_errs = err_cnt;
    endtask

    task automatic end_test();
        n_tests++;
        if (err_cnt == start_errs) begin
            $display("test %0d %s: ok", n_tests, cur_test);
        end else begin
            n_failed++;
            $display("test %0d %s: failed, %0d errors", n_tests, cur_test, err_cnt - start_errs);
        end
    endtask

    // New issue shows as rd_en leaving zero, fields are settled by then
    always @(negedge clk) begin
        if (rst_n && o_rd_en != '0 && prev_rd_en == '0) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Read ports enabled at %0t with no legal command pending", $time);
            end else begin
                n_issues++;
                check_op("o_op_type", o_op_type, op_type_e'(t_op[exp_q[0]]));
                check_num("o_op_num", o_op_num, t_num[exp_q[0]]);
                check_addr("o_weight_addr", o_weight_addr, t_wa[exp_q[0]]);
                check_addr("o_data_addr", o_data_addr, t_da[exp_q[0]]);
                check_addr("o_wb_addr", o_wb_addr, t_wb[exp_q[0]]);
                check_ports("o_rd_en", o_rd_en, ports_for(t_op[exp_q[0]]));
                check_bit("o_op_run", o_op_run, 1'b1);
                void'(exp_q.pop_front());
            end
        end
        prev_rd_en = o_rd_en;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: run still going after %0d cycles", wd_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic              err;
        logic              busy_err;
        logic              busy_run;
        logic [APB_DW-1:0] rd_unmapped;  // Read data of the unmapped access
        rst_n     = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        set_row(0, CONV1X1, 16'd32, 16'd1, 32'h1000_0000, 32'h2000_0000, 32'h3000_0000);
        set_row(1, CONV3X3, 16'd64, 16'd2, 32'h1000_1000, 32'h2000_1000, 32'h3000_1000);
        set_row(2, 3'd6, 16'd16, 16'd3, 32'hDEAD_0000, 32'hDEAD_0004, 32'hDEAD_0008);
        set_row(3, CONV3X3_PAD, 16'd0, 16'd4, 32'h1000_2000, 32'h2000_2000, 32'h3000_2000);
        set_row(4, MAXPOOL, 16'd48, 16'd5, 32'h1000_3000, 32'h2000_3000, 32'h3000_3000);
        set_row(5, AVEPOOL, 16'd17, 16'd6, 32'h1000_4000, 32'h2000_4000, 32'h3000_4000);
        for (int r = N_FIXED; r < N_ROWS; r++)
            set_row(r, OP_W'(rand_bits(3)), CH_W'(rand_bits(7)), CH_W'(rand_bits(16)),
                    rand_bits(32), rand_bits(32), rand_bits(32));
        for (int r = 0; r < N_ROWS; r++) begin
            if (is_legal(t_op[r])) begin
                exp_q.push_back(r);
                n_legal++;
            end
            wd_cycles += groups_of(t_och[r]) * 7 + 20;  // Slowest engine
        end
        wd_cycles += WD_MARGIN;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset state");
        @(negedge clk);
        check_ports("o_rd_en", o_rd_en, '0);
        check_bit("o_irq", o_irq, 1'b0);
        check_bit("o_op_run", o_op_run, 1'b0);
        read_check(REG_STATUS, "STATUS", '0);
        end_test();

        begin_test("command batch");
        for (int r = 0; r < N_ROWS; r++)
            for (int w = 0; w < CMD_WORDS; w++) begin
                apb_write(REG_CMD, cmd_word(r, w), err);
                check_bit("o_pslverr", err, 1'b0);
            end
        apb_write(REG_CTRL, 32'h1, err);
        while (o_op_run !== 1'b1) @(negedge clk);
        apb_write(REG_CTRL, 32'h1, busy_err);  // Sequencer busy, must be ignored
        @(negedge clk);
        busy_run = o_op_run;
        while (o_irq !== 1'b1) @(negedge clk);
        report(n_issues == n_legal, "issue count", $sformatf("%0d", n_issues),
               $sformatf("%0d", n_legal));
        end_test();

        begin_test("start while busy");
        check_bit("o_pslverr", busy_err, 1'b0);
        check_bit("o_op_run", busy_run, 1'b1);
        read_check(REG_OPS, "OPS", APB_DW'(n_legal));  // Each command once
        end_test();

        begin_test("irq and bad command");
        check_bit("o_irq", o_irq, 1'b1);
        read_check(REG_STATUS, "STATUS", 32'h0000_0005);  // irq and bad_cmd
        apb_write(REG_IRQ_CLR, 32'h1, err);
        @(negedge clk);
        check_bit("o_irq", o_irq, 1'b0);
        read_check(REG_STATUS, "STATUS", '0);
        end_test();

        begin_test("fifo overflow and unmapped");
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            apb_write(REG_CMD, 32'hC0DE_0000 | 32'(i), err);
            check_bit("o_pslverr", err, (i == FIFO_DEPTH));  // Only the 65th is refused
        end
        read_check(REG_STATUS, "STATUS", APB_DW'(FIFO_DEPTH) << ST_CNT_LSB);
        apb_read(8'h14, rd_unmapped, err);
        check_bit("o_pslverr", err, 1'b1);
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/cnn_cmd_pkg.sv
src/cnn_bus_pkg.sv
src/cmd_fifo.sv
src/csb_apb_regs.sv
src/csb_sequencer.sv
src/dma_port_ctrl.sv
src/group_engine.sv
src/cnn_ctrl_top.sv
verif/tb_cnn_ctrl.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_cnn_ctrl \
    && ./obj_dir/Vtb_cnn_ctrl > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
